/* design/rvCtrlPkg.sv */
package rvCtrlPkg;

    // instruction field widths
    localparam int opWidth     = 7;
    localparam int funct3Width = 3;
    localparam int funct7Width = 7;

    // major opcodes, raw RV32I encodings
    typedef enum logic [opWidth-1:0] {
        opIllegal = 7'b0000000, // anything not listed below
        opLoad    = 7'b0000011,
        opImm     = 7'b0010011,
        opAuipc   = 7'b0010111,
        opStore   = 7'b0100011,
        opReg     = 7'b0110011,
        opLui     = 7'b0110111,
        opBranch  = 7'b1100011,
        opJalr    = 7'b1100111,
        opJal     = 7'b1101111
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluXor = 3'b010,
        aluOr  = 3'b011,
        aluAnd = 3'b100,
        aluSll = 3'b101,
        aluSrl = 3'b110,
        aluSra = 3'b111
    } aluOpT;

    // rd write data source
    typedef enum logic [1:0] {
        dstAlu     = 2'b00,
        dstMem     = 2'b01,
        dstPcPlus4 = 2'b10,
        dstCmp     = 2'b11  // slt family, from comparator
    } regDstT;

    typedef enum logic [2:0] {
        extI     = 3'b000,
        extS     = 3'b001,
        extB     = 3'b010,
        extU     = 3'b011,
        extJ     = 3'b100,
        extShamt = 3'b101
    } extSelT;

    // memory access size, matches funct3[1:0]
    typedef enum logic [1:0] {
        widthByte = 2'b00,
        widthHalf = 2'b01,
        widthWord = 2'b10
    } widthT;

    typedef enum logic [1:0] {
        cmpEq = 2'b00,
        cmpLt = 2'b01,
        cmpGt = 2'b10   // 2'b11 never driven
    } cmpT;

    typedef struct packed {
        aluOpT  aluOp;
        logic   alu1Src;  // 1: pc
        logic   alu2Src;  // 1: immediate
        extSelT extSel;
        logic   sign;
    } aluCtrlT;

    typedef struct packed {
        widthT  width;
        logic   dataWr;
        logic   regWr;
        regDstT regDst;
        logic   immRes;   // lui writes imm directly
    } memWbCtrlT;

    typedef struct packed {
        logic      pcSrc;
        aluCtrlT   aluCtrl;
        memWbCtrlT memWbCtrl;
    } ctrlT;

endpackage

/* design/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder import rvCtrlPkg::*; (
    input  opcodeT                 opcode,
    input  logic [funct3Width-1:0] funct3,
    input  logic [funct7Width-1:0] funct7,
    output aluCtrlT                aluCtrl
);

    logic altFunc;  // sub / sra select
    logic isImm;

    assign altFunc = funct7[5];
    assign isImm   = (opcode == opImm);

    always_comb
    begin
        aluCtrl.aluOp   = aluAdd;
        aluCtrl.alu1Src = 1'b0;
        aluCtrl.alu2Src = 1'b0;
        aluCtrl.extSel  = extI;
        aluCtrl.sign    = 1'b1;

        case (opcode)
            opReg, opImm:
            begin
                aluCtrl.alu2Src = isImm;
                case (funct3)
                    3'b000: aluCtrl.aluOp = (!isImm && altFunc) ? aluSub : aluAdd;
                    3'b001: aluCtrl.aluOp = aluSll;
                    3'b011: aluCtrl.sign  = 1'b0;  // sltu / sltiu
                    3'b100: aluCtrl.aluOp = aluXor;
                    3'b101: aluCtrl.aluOp = altFunc ? aluSra : aluSrl;
                    3'b110: aluCtrl.aluOp = aluOr;
                    3'b111: aluCtrl.aluOp = aluAnd;
                    default: ;  // slt keeps add
                endcase
                // slli, srli, srai
                if (isImm && funct3[1:0] == 2'b01)
                begin
                    aluCtrl.extSel = extShamt;
                end
            end
            opLoad:
            begin
                aluCtrl.alu2Src = 1'b1;
                if (funct3 == 3'b100 || funct3 == 3'b101)
                begin
                    aluCtrl.sign = 1'b0;  // lbu, lhu
                end
            end
            opStore:
            begin
                aluCtrl.alu2Src = 1'b1;
                aluCtrl.extSel  = extS;
            end
            opBranch:
            begin
                aluCtrl.alu1Src = 1'b1;  // target = pc + imm
                aluCtrl.alu2Src = 1'b1;
                aluCtrl.extSel  = extB;
                aluCtrl.sign    = !(funct3[2:1] == 2'b11);  // bltu, bgeu unsigned
            end
            opJal:
            begin
                aluCtrl.alu1Src = 1'b1;
                aluCtrl.alu2Src = 1'b1;
                aluCtrl.extSel  = extJ;
            end
            opJalr: aluCtrl.alu2Src = 1'b1;
            opLui:
            begin
                aluCtrl.alu2Src = 1'b1;
                aluCtrl.extSel  = extU;
            end
            opAuipc:
            begin
                aluCtrl.alu1Src = 1'b1;
                aluCtrl.alu2Src = 1'b1;
                aluCtrl.extSel  = extU;
            end
            default: ;
        endcase
    end

endmodule

/* design/branchResolver.sv */
`timescale 1ns/1ps

module branchResolver import rvCtrlPkg::*; (
    input  opcodeT                 opcode,
    input  logic [funct3Width-1:0] funct3,
    input  cmpT                    cmp,
    output logic                   pcSrc
);

    logic isEq;
    logic isLt;
    logic isGe;

    assign isEq = (cmp == cmpEq);
    assign isLt = (cmp == cmpLt);
    assign isGe = (cmp == cmpEq) || (cmp == cmpGt);

    always_comb
    begin
        pcSrc = 1'b0;
        case (opcode)
            opJal, opJalr: pcSrc = 1'b1;
            opBranch:
            begin
                case (funct3)
                    3'b000: pcSrc = isEq;           // beq
                    3'b001: pcSrc = !isEq;          // bne
                    3'b100, 3'b110: pcSrc = isLt;   // blt, bltu
                    3'b101, 3'b111: pcSrc = isGe;   // bge, bgeu
                    default: pcSrc = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    // comparator must give a real result while a branch is decoded
    branchCmpLegal: assert final (!(opcode == opBranch && cmp == 2'b11))
        else $error("comparator result 11 on a branch");

endmodule

/* design/memWbDecoder.sv */
`timescale 1ns/1ps

module memWbDecoder import rvCtrlPkg::*; (
    input  opcodeT                 opcode,
    input  logic [funct3Width-1:0] funct3,
    output memWbCtrlT              memWbCtrl
);

    logic isSlt;
    widthT accessWidth;

    // slt, sltu, slti, sltiu
    assign isSlt       = (funct3 == 3'b010) || (funct3 == 3'b011);
    assign accessWidth = widthT'(funct3[1:0]);

    always_comb
    begin
        memWbCtrl.width  = widthWord;
        memWbCtrl.dataWr = 1'b0;
        memWbCtrl.regWr  = 1'b0;
        memWbCtrl.regDst = dstAlu;
        memWbCtrl.immRes = 1'b0;

        case (opcode)
            opLoad:
            begin
                memWbCtrl.width  = accessWidth;
                memWbCtrl.regWr  = 1'b1;
                memWbCtrl.regDst = dstMem;
            end
            opStore:
            begin
                memWbCtrl.width  = accessWidth;
                memWbCtrl.dataWr = 1'b1;
            end
            opReg, opImm:
            begin
                memWbCtrl.regWr  = 1'b1;
                memWbCtrl.regDst = isSlt ? dstCmp : dstAlu;
            end
            opJal, opJalr:
            begin
                memWbCtrl.regWr  = 1'b1;
                memWbCtrl.regDst = dstPcPlus4;  // link address
            end
            opAuipc: memWbCtrl.regWr = 1'b1;
            opLui:
            begin
                memWbCtrl.regWr  = 1'b1;
                memWbCtrl.immRes = 1'b1;
            end
            default: ;  // branches and illegal write nothing
        endcase
    end

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import rvCtrlPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instValid,
    input  logic [opWidth-1:0]     op,
    input  logic [funct3Width-1:0] funct3,
    input  logic [funct7Width-1:0] funct7,
    input  cmpT                    cmp,
    output ctrlT                   ctrl,
    output logic                   ctrlValid
);

    opcodeT    opcode;
    aluCtrlT   aluCtrl;
    memWbCtrlT memWbCtrl;
    logic      pcSrc;
    ctrlT      ctrlNext;

    // unknown opcodes fall back to opIllegal
    always_comb
    begin
        case (op)
            opReg, opImm, opLoad, opStore, opBranch,
            opJal, opJalr, opLui, opAuipc: opcode = opcodeT'(op);
            default: opcode = opIllegal;
        endcase
    end

    aluDecoder uAluDecoder (
        .opcode  (opcode),
        .funct3  (funct3),
        .funct7  (funct7),
        .aluCtrl (aluCtrl)
    );

    branchResolver uBranchResolver (
        .opcode (opcode),
        .funct3 (funct3),
        .cmp    (cmp),
        .pcSrc  (pcSrc)
    );

    memWbDecoder uMemWbDecoder (
        .opcode    (opcode),
        .funct3    (funct3),
        .memWbCtrl (memWbCtrl)
    );

    assign ctrlNext = '{pcSrc: pcSrc, aluCtrl: aluCtrl, memWbCtrl: memWbCtrl};

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            ctrl      <= '0;
            ctrlValid <= 1'b0;
        end
        else
        begin
            ctrlValid <= instValid;
            if (instValid)
                ctrl <= ctrlNext;  // hold otherwise
        end
    end

    validFollowsStrobe: assert property (@(posedge clk) disable iff (!arstN)
        ctrlValid |-> $past(instValid));

    // loads write rd, stores write memory, never both
    noDoubleWrite: assert property (@(posedge clk) disable iff (!arstN)
        ctrlValid |-> !(ctrl.memWbCtrl.regWr && ctrl.memWbCtrl.dataWr));

endmodule

/* sim/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb import rvCtrlPkg::*; ();

    localparam int maxCycles = 1500;  // tests run for about 1200 cycles

    logic                   clk;
    logic                   arstN;
    logic                   instValid;
    logic [opWidth-1:0]     op;
    logic [funct3Width-1:0] funct3;
    logic [funct7Width-1:0] funct7;
    cmpT                    cmp;
    ctrlT                   ctrl;
    logic                   ctrlValid;

    ctrlT   expQ[$];
    ctrlT   expWord;
    logic   strobeSeen;
    int     cycleCount = 0;
    integer seed = 32'hc892;

    controlUnit DUT (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .op        (op),
        .funct3    (funct3),
        .funct7    (funct7),
        .cmp       (cmp),
        .ctrl      (ctrl),
        .ctrlValid (ctrlValid)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected control word from the decode rules
    function automatic ctrlT refCtrl(input logic [opWidth-1:0] opIn,
                                     input logic [funct3Width-1:0] f3,
                                     input logic [funct7Width-1:0] f7,
                                     input cmpT cmpIn);
        ctrlT r;
        r = '0;
        r.aluCtrl.aluOp    = aluAdd;
        r.aluCtrl.extSel   = extI;
        r.aluCtrl.sign     = 1'b1;
        r.memWbCtrl.width  = widthWord;
        r.memWbCtrl.regDst = dstAlu;
        case (opIn)
            opReg, opImm:
            begin
                r.aluCtrl.alu2Src = (opIn == opImm);
                r.memWbCtrl.regWr = 1'b1;
                case (f3)
                    3'b000: r.aluCtrl.aluOp = (opIn == opReg && f7[5]) ? aluSub : aluAdd;
                    3'b001: r.aluCtrl.aluOp = aluSll;
                    3'b010: r.memWbCtrl.regDst = dstCmp;
                    3'b011:
                    begin
                        r.memWbCtrl.regDst = dstCmp;
                        r.aluCtrl.sign     = 1'b0;
                    end
                    3'b100: r.aluCtrl.aluOp = aluXor;
                    3'b101: r.aluCtrl.aluOp = f7[5] ? aluSra : aluSrl;
                    3'b110: r.aluCtrl.aluOp = aluOr;
                    default: r.aluCtrl.aluOp = aluAnd;
                endcase
                if (opIn == opImm && (f3 == 3'b001 || f3 == 3'b101))
                    r.aluCtrl.extSel = extShamt;
            end
            opLoad:
            begin
                r.aluCtrl.alu2Src  = 1'b1;
                r.aluCtrl.sign     = !(f3 == 3'b100 || f3 == 3'b101);
                r.memWbCtrl.width  = widthT'(f3[1:0]);
                r.memWbCtrl.regWr  = 1'b1;
                r.memWbCtrl.regDst = dstMem;
            end
            opStore:
            begin
                r.aluCtrl.alu2Src  = 1'b1;
                r.aluCtrl.extSel   = extS;
                r.memWbCtrl.width  = widthT'(f3[1:0]);
                r.memWbCtrl.dataWr = 1'b1;
            end
            opBranch:
            begin
                r.aluCtrl.alu1Src = 1'b1;
                r.aluCtrl.alu2Src = 1'b1;
                r.aluCtrl.extSel  = extB;
                r.aluCtrl.sign    = !(f3 == 3'b110 || f3 == 3'b111);
                case (f3)
                    3'b000: r.pcSrc = (cmpIn == cmpEq);
                    3'b001: r.pcSrc = (cmpIn != cmpEq);
                    3'b100, 3'b110: r.pcSrc = (cmpIn == cmpLt);
                    3'b101, 3'b111: r.pcSrc = (cmpIn == cmpEq) || (cmpIn == cmpGt);
                    default: r.pcSrc = 1'b0;
                endcase
            end
            opJal, opJalr:
            begin
                r.pcSrc            = 1'b1;
                r.aluCtrl.alu1Src  = (opIn == opJal);
                r.aluCtrl.alu2Src  = 1'b1;
                r.aluCtrl.extSel   = (opIn == opJal) ? extJ : extI;
                r.memWbCtrl.regWr  = 1'b1;
                r.memWbCtrl.regDst = dstPcPlus4;
            end
            opLui:
            begin
                r.aluCtrl.alu2Src  = 1'b1;
                r.aluCtrl.extSel   = extU;
                r.memWbCtrl.regWr  = 1'b1;
                r.memWbCtrl.immRes = 1'b1;
            end
            opAuipc:
            begin
                r.aluCtrl.alu1Src = 1'b1;  // pc + imm
                r.aluCtrl.alu2Src = 1'b1;
                r.aluCtrl.extSel  = extU;
                r.memWbCtrl.regWr = 1'b1;
            end
            default: ;  // unknown opcode keeps all defaults
        endcase
        return r;
    endfunction

    function automatic logic [opWidth-1:0] randomOpcode(input int idx);
        case (idx)
            0: return opReg;
            1: return opImm;
            2: return opLoad;
            3: return opStore;
            4: return opBranch;
            5: return opJal;
            6: return opJalr;
            7: return opLui;
            default: return opAuipc;
        endcase
    endfunction

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkCtrl(input string name, input ctrlT actual, input ctrlT expected);
        if (actual !== expected)
            abortRun($sformatf("** Error: %s expected 0x%h, actual 0x%h", name, expected, actual));
    endtask

    task automatic checkValid(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            abortRun($sformatf("** Error: %s expected 0x%h, actual 0x%h", name, expected, actual));
    endtask

    task automatic sendInst(input logic [opWidth-1:0] opIn, input logic [funct3Width-1:0] f3,
                            input logic [funct7Width-1:0] f7, input cmpT cmpIn);
        @(posedge clk);
        #1;
        instValid = 1'b1;
        op        = opIn;
        funct3    = f3;
        funct7    = f7;
        cmp       = cmpIn;
        expQ.push_back(refCtrl(opIn, f3, f7, cmpIn));
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        instValid = 1'b0;
    endtask

    always @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            strobeSeen <= 1'b0;
        else
            strobeSeen <= instValid;
    end

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (arstN)
        begin
            checkValid("ctrlValid", ctrlValid, strobeSeen);
            if (ctrlValid)
            begin
                if (expQ.size() == 0)
                    abortRun("an unexpected control word appeared with no instruction pending");
                if (ctrl.memWbCtrl.regWr && ctrl.memWbCtrl.dataWr)
                    abortRun("a control word had both register and memory write set");
                expWord = expQ.pop_front();
                checkCtrl("ctrl", ctrl, expWord);
            end
        end
    end

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= maxCycles)
            abortRun("the run timed out before all tests finished");
    end

    initial
    begin
        int f3;
        int alt;
        int c;
        int i;
        arstN     = 1'b0;
        instValid = 1'b0;
        op        = '0;
        funct3    = '0;
        funct7    = '0;
        cmp       = cmpEq;
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;

        // reset state holds until the first strobe
        repeat (2)
        begin
            @(negedge clk);
            checkValid("ctrlValid", ctrlValid, 1'b0);
            checkCtrl("ctrl", ctrl, '0);
        end

        for (f3 = 0; f3 < 8; f3++)
            for (alt = 0; alt < 2; alt++)
            begin
                sendInst(opReg, f3, alt ? 7'h20 : 7'h00, cmpEq);
                sendInst(opImm, f3, alt ? 7'h20 : 7'h00, cmpEq);
            end
        idleCycle();

        for (f3 = 0; f3 < 6; f3++)
            if (f3 != 3)
                sendInst(opLoad, f3, 7'h00, cmpEq);
        for (f3 = 0; f3 < 3; f3++)
            sendInst(opStore, f3, 7'h00, cmpEq);
        idleCycle();

        for (f3 = 0; f3 < 8; f3++)
            if (f3 != 2 && f3 != 3)
                for (c = 0; c < 3; c++)
                    sendInst(opBranch, f3, 7'h00, cmpT'(c));
        sendInst(opJal, 3'b000, 7'h00, cmpLt);
        sendInst(opJalr, 3'b000, 7'h00, cmpGt);
        idleCycle();

        sendInst(opLui, 3'b000, 7'h00, cmpEq);
        sendInst(opAuipc, 3'b000, 7'h00, cmpEq);
        sendInst(7'b0001111, 3'b000, 7'h00, cmpEq);  // fence, not decoded
        sendInst(7'b1111111, 3'b111, 7'h7f, cmpGt);
        idleCycle();

        for (i = 0; i < 1000; i++)
        begin
            sendInst(randomOpcode($unsigned($random(seed)) % 9), $random(seed), $random(seed),
                     cmpT'($unsigned($random(seed)) % 3));
            if (i % 10 == 9)
                idleCycle();
        end
        idleCycle();

        while (expQ.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

/* controlUnit.f */
design/rvCtrlPkg.sv
design/aluDecoder.sv
design/branchResolver.sv
design/memWbDecoder.sv
design/controlUnit.sv
sim/controlUnitTb.sv

/* Bender.yml */
package:
  name: controlUnit

sources:
  - files:
      - design/rvCtrlPkg.sv
      - design/aluDecoder.sv
      - design/branchResolver.sv
      - design/memWbDecoder.sv
      - design/controlUnit.sv
  - target: simulation
    files:
      - sim/controlUnitTb.sv
